// ==== design/mips_int_macros.svh ====
`ifndef MIPS_INT_MACROS_SVH
`define MIPS_INT_MACROS_SVH

`define INST_W       32
`define REG_ADDR_W   5
`define REG_NUM      32

// opcode field, inst[31:26]
`define OPC_SPECIAL  6'b000000
`define OPC_ADDI     6'b001000
`define OPC_ADDIU    6'b001001
`define OPC_SLTI     6'b001010
`define OPC_SLTIU    6'b001011
`define OPC_ANDI     6'b001100
`define OPC_ORI      6'b001101
`define OPC_XORI     6'b001110
`define OPC_LUI      6'b001111
`define OPC_PREF     6'b110011

// funct field of SPECIAL, inst[5:0]
`define FN_SLL       6'b000000
`define FN_SRL       6'b000010
`define FN_SRA       6'b000011
`define FN_SLLV      6'b000100
`define FN_SRLV      6'b000110
`define FN_SRAV      6'b000111
`define FN_SYNC      6'b001111
`define FN_ADD       6'b100000
`define FN_ADDU      6'b100001
`define FN_SUB       6'b100010
`define FN_SUBU      6'b100011
`define FN_AND       6'b100100
`define FN_OR        6'b100101
`define FN_XOR       6'b100110
`define FN_NOR       6'b100111
`define FN_SLT       6'b101010
`define FN_SLTU      6'b101011

`endif

// ==== design/mips_int_pkg.sv ====
`default_nettype none

`include "mips_int_macros.svh"

package mips_int_pkg;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm16;
    } inst_i_t;

    // one instruction word in two field layouts
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_word_u;

    typedef enum logic [3:0] {
        ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_NOP
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH
    } alu_sel_e;

endpackage

`default_nettype wire

// ==== design/inst_decode.sv ====
`default_nettype none

`include "mips_int_macros.svh"

module inst_decode (
    input  wire logic                   inst_valid_i,
    input  wire logic [`INST_W-1:0]     inst_i,
    input  wire logic [`INST_W-1:0]     rs_data_i,
    input  wire logic [`INST_W-1:0]     rt_data_i,
    input  wire logic                   ex_wreg_i,
    input  wire logic [`REG_ADDR_W-1:0] ex_wd_i,
    input  wire logic [`INST_W-1:0]     ex_wdata_i,
    input  wire logic                   wb_we_i,
    input  wire logic [`REG_ADDR_W-1:0] wb_addr_i,
    input  wire logic [`INST_W-1:0]     wb_data_i,
    output logic [`REG_ADDR_W-1:0]      rs_addr_o,
    output logic [`REG_ADDR_W-1:0]      rt_addr_o,
    output logic                        dec_valid_o,
    output mips_int_pkg::alu_op_e       dec_op_o,
    output mips_int_pkg::alu_sel_e      dec_sel_o,
    output logic [`INST_W-1:0]          dec_opnd1_o,
    output logic [`INST_W-1:0]          dec_opnd2_o,
    output logic [`REG_ADDR_W-1:0]      dec_wd_o,
    output logic                        dec_wreg_o,
    output logic                        dec_invalid_o
);

    mips_int_pkg::inst_word_u inst_w;
    logic                     rd1;           // opnd1 from rs
    logic                     rd2;           // opnd2 from rt
    logic                     wreg;
    logic                     inst_ok;
    logic [`INST_W-1:0]       imm;
    logic [`REG_ADDR_W-1:0]   wd;

    // newest in-flight write wins over the register file
    function automatic logic [`INST_W-1:0] pick_opnd(
        input logic                   rd,
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`INST_W-1:0]     rf_data,
        input logic [`INST_W-1:0]     imm_val,
        input logic                   ex_wreg,
        input logic [`REG_ADDR_W-1:0] ex_wd,
        input logic [`INST_W-1:0]     ex_wdata,
        input logic                   wb_we,
        input logic [`REG_ADDR_W-1:0] wb_addr,
        input logic [`INST_W-1:0]     wb_data
    );
        if (!rd) begin
            return imm_val;
        end else if (ex_wreg && ex_wd == addr) begin
            return ex_wdata;
        end else if (wb_we && wb_addr == addr) begin
            return wb_data;
        end
        return rf_data;
    endfunction

    assign inst_w    = inst_i;
    assign rs_addr_o = inst_w.r.rs;
    assign rt_addr_o = inst_w.r.rt;

    always_comb begin
        dec_op_o  = mips_int_pkg::ALU_NOP;
        dec_sel_o = mips_int_pkg::SEL_NOP;
        wd        = inst_w.r.rd;             // rd unless I-type
        wreg      = 1'b0;
        inst_ok   = 1'b0;
        rd1       = 1'b0;
        rd2       = 1'b0;
        imm       = '0;

        case (inst_w.r.opcode)
            `OPC_SPECIAL: begin
                case (inst_w.r.funct)
                    `FN_OR:   {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_OR,   mips_int_pkg::SEL_LOGIC};
                    `FN_AND:  {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_AND,  mips_int_pkg::SEL_LOGIC};
                    `FN_XOR:  {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_XOR,  mips_int_pkg::SEL_LOGIC};
                    `FN_NOR:  {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_NOR,  mips_int_pkg::SEL_LOGIC};
                    `FN_SLL,
                    `FN_SLLV: {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_SLL,  mips_int_pkg::SEL_SHIFT};
                    `FN_SRL,
                    `FN_SRLV: {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_SRL,  mips_int_pkg::SEL_SHIFT};
                    `FN_SRA,
                    `FN_SRAV: {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_SRA,  mips_int_pkg::SEL_SHIFT};
                    `FN_ADD,
                    `FN_ADDU: {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_ADD,  mips_int_pkg::SEL_ARITH};
                    `FN_SUB,
                    `FN_SUBU: {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_SUB,  mips_int_pkg::SEL_ARITH};
                    `FN_SLT:  {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_SLT,  mips_int_pkg::SEL_ARITH};
                    `FN_SLTU: {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_SLTU, mips_int_pkg::SEL_ARITH};
                    `FN_SYNC: inst_ok = 1'b1;
                    default: ;
                endcase
                if (inst_w.r.funct inside {`FN_SLL, `FN_SRL, `FN_SRA}) begin
                    rd2     = 1'b1;
                    imm     = {{(`INST_W-5){1'b0}}, inst_w.r.shamt};  // shift amount
                    inst_ok = (inst_w.r.rs == '0);
                    wreg    = inst_ok;
                end else if (dec_sel_o != mips_int_pkg::SEL_NOP) begin
                    rd1     = 1'b1;
                    rd2     = 1'b1;
                    inst_ok = (inst_w.r.shamt == '0);
                    wreg    = inst_ok;
                end
            end
            `OPC_ORI: begin
                {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_OR, mips_int_pkg::SEL_LOGIC};
                imm = {16'h0, inst_w.i.imm16};
            end
            `OPC_ANDI: begin
                {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_AND, mips_int_pkg::SEL_LOGIC};
                imm = {16'h0, inst_w.i.imm16};
            end
            `OPC_XORI: begin
                {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_XOR, mips_int_pkg::SEL_LOGIC};
                imm = {16'h0, inst_w.i.imm16};
            end
            `OPC_LUI: begin
                {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_OR, mips_int_pkg::SEL_LOGIC};
                imm = {inst_w.i.imm16, 16'h0};
            end
            `OPC_ADDI,
            `OPC_ADDIU: begin
                {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_ADD, mips_int_pkg::SEL_ARITH};
                imm = {{16{inst_w.i.imm16[15]}}, inst_w.i.imm16};
            end
            `OPC_SLTI: begin
                {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_SLT, mips_int_pkg::SEL_ARITH};
                imm = {{16{inst_w.i.imm16[15]}}, inst_w.i.imm16};
            end
            `OPC_SLTIU: begin
                {dec_op_o, dec_sel_o} = {mips_int_pkg::ALU_SLTU, mips_int_pkg::SEL_ARITH};
                imm = {{16{inst_w.i.imm16[15]}}, inst_w.i.imm16};  // signed imm, unsigned compare
            end
            `OPC_PREF: inst_ok = 1'b1;
            default: ;
        endcase

        if (inst_w.i.opcode != `OPC_SPECIAL && dec_sel_o != mips_int_pkg::SEL_NOP) begin
            rd1     = (inst_w.i.opcode != `OPC_LUI);  // lui ignores rs
            wd      = inst_w.i.rt;
            wreg    = 1'b1;
            inst_ok = 1'b1;
        end

        dec_wreg_o    = inst_valid_i && wreg && (wd != '0);
        dec_invalid_o = inst_valid_i && !inst_ok;
    end

    assign dec_valid_o = inst_valid_i;
    assign dec_wd_o    = wd;

    assign dec_opnd1_o = pick_opnd(rd1, rs_addr_o, rs_data_i, imm, ex_wreg_i, ex_wd_i,
                                   ex_wdata_i, wb_we_i, wb_addr_i, wb_data_i);
    assign dec_opnd2_o = pick_opnd(rd2, rt_addr_o, rt_data_i, imm, ex_wreg_i, ex_wd_i,
                                   ex_wdata_i, wb_we_i, wb_addr_i, wb_data_i);

    always_comb begin
        if (inst_valid_i) begin
            assert (!(dec_wreg_o && dec_invalid_o))
                else $error("invalid instruction %h requests a write", inst_i);
        end
    end

endmodule

`default_nettype wire

// ==== design/alu_exec.sv ====
`default_nettype none

`include "mips_int_macros.svh"

module alu_exec (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   dec_valid_i,
    input  wire mips_int_pkg::alu_op_e  dec_op_i,
    input  wire mips_int_pkg::alu_sel_e dec_sel_i,
    input  wire logic [`INST_W-1:0]     dec_opnd1_i,
    input  wire logic [`INST_W-1:0]     dec_opnd2_i,
    input  wire logic [`REG_ADDR_W-1:0] dec_wd_i,
    input  wire logic                   dec_wreg_i,
    input  wire logic                   dec_invalid_i,
    output logic                        ex_valid_o,
    output logic                        ex_wreg_o,
    output logic [`REG_ADDR_W-1:0]      ex_wd_o,
    output logic [`INST_W-1:0]          ex_wdata_o,
    output logic                        ex_invalid_o
);

    mips_int_pkg::alu_op_e  op_q;
    mips_int_pkg::alu_sel_e sel_q;
    logic [`INST_W-1:0]     opnd1_q;
    logic [`INST_W-1:0]     opnd2_q;
    logic [`INST_W-1:0]     logic_res;
    logic [`INST_W-1:0]     shift_res;
    logic [`INST_W-1:0]     arith_res;
    logic [4:0]             sa;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_o   <= 1'b0;
            ex_wreg_o    <= 1'b0;
            ex_invalid_o <= 1'b0;
        end else begin
            ex_valid_o   <= dec_valid_i;
            ex_wreg_o    <= dec_wreg_i;
            ex_invalid_o <= dec_invalid_i;
        end
    end

    always_ff @(posedge clk) begin
        op_q    <= dec_op_i;
        sel_q   <= dec_sel_i;
        opnd1_q <= dec_opnd1_i;
        opnd2_q <= dec_opnd2_i;
        ex_wd_o <= dec_wd_i;
    end

    assign sa = opnd1_q[4:0];  // shamt or rs[4:0]

    always_comb begin
        case (op_q)
            mips_int_pkg::ALU_OR:  logic_res = opnd1_q | opnd2_q;
            mips_int_pkg::ALU_AND: logic_res = opnd1_q & opnd2_q;
            mips_int_pkg::ALU_XOR: logic_res = opnd1_q ^ opnd2_q;
            mips_int_pkg::ALU_NOR: logic_res = ~(opnd1_q | opnd2_q);
            default:               logic_res = '0;
        endcase
    end

    always_comb begin
        case (op_q)
            mips_int_pkg::ALU_SLL: shift_res = opnd2_q << sa;
            mips_int_pkg::ALU_SRL: shift_res = opnd2_q >> sa;
            mips_int_pkg::ALU_SRA: shift_res = $signed(opnd2_q) >>> sa;  // sign fill
            default:               shift_res = '0;
        endcase
    end

    // add and sub wrap without an overflow trap
    always_comb begin
        case (op_q)
            mips_int_pkg::ALU_ADD:  arith_res = opnd1_q + opnd2_q;
            mips_int_pkg::ALU_SUB:  arith_res = opnd1_q - opnd2_q;
            mips_int_pkg::ALU_SLT:  arith_res = {{(`INST_W-1){1'b0}},
                                                 $signed(opnd1_q) < $signed(opnd2_q)};
            mips_int_pkg::ALU_SLTU: arith_res = {{(`INST_W-1){1'b0}}, opnd1_q < opnd2_q};
            default:                arith_res = '0;
        endcase
    end

    always_comb begin
        case (sel_q)
            mips_int_pkg::SEL_LOGIC: ex_wdata_o = logic_res;
            mips_int_pkg::SEL_SHIFT: ex_wdata_o = shift_res;
            mips_int_pkg::SEL_ARITH: ex_wdata_o = arith_res;
            default:                 ex_wdata_o = '0;
        endcase
    end

    a_wreg_has_result : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (ex_valid_o && ex_wreg_o) |-> (sel_q != mips_int_pkg::SEL_NOP)
    ) else $error("register write without a result group");

endmodule

`default_nettype wire

// ==== design/write_back.sv ====
`default_nettype none

`include "mips_int_macros.svh"

module write_back (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   ex_valid_i,
    input  wire logic                   ex_wreg_i,
    input  wire logic [`REG_ADDR_W-1:0] ex_wd_i,
    input  wire logic [`INST_W-1:0]     ex_wdata_i,
    input  wire logic                   ex_invalid_i,
    input  wire logic [`REG_ADDR_W-1:0] rs_addr_i,
    input  wire logic [`REG_ADDR_W-1:0] rt_addr_i,
    output logic [`INST_W-1:0]          rs_data_o,
    output logic [`INST_W-1:0]          rt_data_o,
    output logic                        wb_we_o,
    output logic [`REG_ADDR_W-1:0]      wb_addr_o,
    output logic [`INST_W-1:0]          wb_data_o,
    output logic                        wb_invalid_o
);

    logic [`INST_W-1:0] regs [0:`REG_NUM-1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_we_o      <= 1'b0;
            wb_invalid_o <= 1'b0;
        end else begin
            wb_we_o      <= ex_valid_i && ex_wreg_i;
            wb_invalid_o <= ex_valid_i && ex_invalid_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= ex_wd_i;
        wb_data_o <= ex_wdata_i;
    end

    always_ff @(posedge clk) begin
        if (wb_we_o) begin
            regs[wb_addr_o] <= wb_data_o;  // one edge after the ports
        end
    end

    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];  // $zero
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

    a_no_zero_write : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_we_o |-> (wb_addr_o != '0)
    ) else $error("write-back to register 0");

endmodule

`default_nettype wire

// ==== design/mips_int_top.sv ====
`default_nettype none

`include "mips_int_macros.svh"

module mips_int_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   inst_valid_i,
    input  wire logic [`INST_W-1:0]     inst_i,
    output logic                        wb_we_o,
    output logic [`REG_ADDR_W-1:0]      wb_addr_o,
    output logic [`INST_W-1:0]          wb_data_o,
    output logic                        inst_invalid_o
);

    logic [`REG_ADDR_W-1:0] rs_addr;
    logic [`REG_ADDR_W-1:0] rt_addr;
    logic [`INST_W-1:0]     rs_data;
    logic [`INST_W-1:0]     rt_data;
    logic                   dec_valid;
    mips_int_pkg::alu_op_e  dec_op;
    mips_int_pkg::alu_sel_e dec_sel;
    logic [`INST_W-1:0]     dec_opnd1;
    logic [`INST_W-1:0]     dec_opnd2;
    logic [`REG_ADDR_W-1:0] dec_wd;
    logic                   dec_wreg;
    logic                   dec_invalid;
    logic                   ex_valid;
    logic                   ex_wreg;
    logic [`REG_ADDR_W-1:0] ex_wd;
    logic [`INST_W-1:0]     ex_wdata;
    logic                   ex_invalid;

    inst_decode u_inst_decode (
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .ex_wreg_i     (ex_wreg),
        .ex_wd_i       (ex_wd),
        .ex_wdata_i    (ex_wdata),
        .wb_we_i       (wb_we_o),
        .wb_addr_i     (wb_addr_o),
        .wb_data_i     (wb_data_o),
        .rs_addr_o     (rs_addr),
        .rt_addr_o     (rt_addr),
        .dec_valid_o   (dec_valid),
        .dec_op_o      (dec_op),
        .dec_sel_o     (dec_sel),
        .dec_opnd1_o   (dec_opnd1),
        .dec_opnd2_o   (dec_opnd2),
        .dec_wd_o      (dec_wd),
        .dec_wreg_o    (dec_wreg),
        .dec_invalid_o (dec_invalid)
    );

    alu_exec u_alu_exec (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .dec_valid_i   (dec_valid),
        .dec_op_i      (dec_op),
        .dec_sel_i     (dec_sel),
        .dec_opnd1_i   (dec_opnd1),
        .dec_opnd2_i   (dec_opnd2),
        .dec_wd_i      (dec_wd),
        .dec_wreg_i    (dec_wreg),
        .dec_invalid_i (dec_invalid),
        .ex_valid_o    (ex_valid),
        .ex_wreg_o     (ex_wreg),
        .ex_wd_o       (ex_wd),
        .ex_wdata_o    (ex_wdata),
        .ex_invalid_o  (ex_invalid)
    );

    write_back u_write_back (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ex_valid_i    (ex_valid),
        .ex_wreg_i     (ex_wreg),
        .ex_wd_i       (ex_wd),
        .ex_wdata_i    (ex_wdata),
        .ex_invalid_i  (ex_invalid),
        .rs_addr_i     (rs_addr),
        .rt_addr_i     (rt_addr),
        .rs_data_o     (rs_data),
        .rt_data_o     (rt_data),
        .wb_we_o       (wb_we_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .wb_invalid_o  (inst_invalid_o)
    );

endmodule

`default_nettype wire

// ==== bench/tb_mips_int.sv ====
`default_nettype none

`include "mips_int_macros.svh"

module tb_mips_int;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int WB_DUE     = 2 * CLK_PERIOD + CLK_PERIOD / 2;  // issue edge to sample point

    logic                   clk;
    logic                   rst_n_i;
    logic                   inst_valid_i;
    logic [`INST_W-1:0]     inst_i;
    logic                   wb_we_o;
    logic [`REG_ADDR_W-1:0] wb_addr_o;
    logic [`INST_W-1:0]     wb_data_o;
    logic                   inst_invalid_o;

    integer                 seed;
    int                     n_errors;
    int                     n_issued;
    int                     n_slots;                 // driven clock slots including bubbles
    logic [`INST_W-1:0]     model [0:`REG_NUM-1];

    time                    t_q[$];
    logic                   we_q[$];
    logic [`REG_ADDR_W-1:0] addr_q[$];
    logic [`INST_W-1:0]     data_q[$];
    logic                   inv_q[$];

    mips_int_top DUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .wb_we_o        (wb_we_o),
        .wb_addr_o      (wb_addr_o),
        .wb_data_o      (wb_data_o),
        .inst_invalid_o (inst_invalid_o)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        n_errors++;
        $display("[ERROR] %0t ns: %s expected %h got %h", $time, name, exp, act);
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [4:0] pick_reg();
        int unsigned r;
        r = $random(seed);
        return 5'(1 + r % 31);                       // never $zero
    endfunction

    function automatic logic [4:0] pick_other(input logic [4:0] a, input logic [4:0] b);
        logic [4:0] r;
        r = pick_reg();
        while (r == a || r == b) begin
            r = pick_reg();
        end
        return r;
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sh,
                                           input logic [5:0] fn);
        return {`OPC_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic step();
        @(posedge clk);
        n_slots++;
    endtask

    task automatic check_quiet();
        assert (wb_we_o === 1'b0)
            else report_value("wb_we_o", 32'd0, 32'(wb_we_o));
        assert (inst_invalid_o === 1'b0)
            else report_value("inst_invalid_o", 32'd0, 32'(inst_invalid_o));
    endtask

    // predicts the ISA result, updates the model, then drives the word
    task automatic issue(input logic [31:0] word);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        logic        bad;
        a    = model[word[25:21]];
        b    = model[word[20:16]];
        simm = {{16{word[15]}}, word[15:0]};
        dst  = word[20:16];
        res  = '0;
        wr   = 1'b1;
        bad  = 1'b0;
        case (word[31:26])
            `OPC_SPECIAL: begin
                dst = word[15:11];
                case (word[5:0])
                    `FN_OR:            res = a | b;
                    `FN_AND:           res = a & b;
                    `FN_XOR:           res = a ^ b;
                    `FN_NOR:           res = ~(a | b);
                    `FN_SLL:           res = b << word[10:6];
                    `FN_SRL:           res = b >> word[10:6];
                    `FN_SRA:           res = $signed(b) >>> word[10:6];
                    `FN_SLLV:          res = b << a[4:0];
                    `FN_SRLV:          res = b >> a[4:0];
                    `FN_SRAV:          res = $signed(b) >>> a[4:0];
                    `FN_ADD, `FN_ADDU: res = a + b;
                    `FN_SUB, `FN_SUBU: res = a - b;
                    `FN_SLT:           res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FN_SLTU:          res = (a < b) ? 32'd1 : 32'd0;
                    `FN_SYNC:          wr = 1'b0;
                    default: begin
                        wr  = 1'b0;
                        bad = 1'b1;
                    end
                endcase
            end
            `OPC_ORI:              res = a | {16'h0, word[15:0]};
            `OPC_ANDI:             res = a & {16'h0, word[15:0]};
            `OPC_XORI:             res = a ^ {16'h0, word[15:0]};
            `OPC_LUI:              res = {word[15:0], 16'h0};
            `OPC_ADDI, `OPC_ADDIU: res = a + simm;
            `OPC_SLTI:             res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            `OPC_SLTIU:            res = (a < simm) ? 32'd1 : 32'd0;
            `OPC_PREF:             wr = 1'b0;
            default: begin
                wr  = 1'b0;
                bad = 1'b1;
            end
        endcase
        if (dst == 5'd0) begin
            wr = 1'b0;                               // $zero stays zero
        end
        if (wr) begin
            model[dst] = res;
        end
        step();
        inst_i       <= word;
        inst_valid_i <= 1'b1;
        t_q.push_back($time);
        we_q.push_back(wr);
        addr_q.push_back(dst);
        data_q.push_back(res);
        inv_q.push_back(bad);
        n_issued++;
    endtask

    task automatic bubble();
        step();
        inst_valid_i <= 1'b0;
    endtask

    task automatic flush();
        repeat (3) bubble();
    endtask

    task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
        issue(i_word(`OPC_LUI, 5'd0, r, v[31:16]));
        issue(i_word(`OPC_ORI, r, r, v[15:0]));
    endtask

    task automatic test_reset();
        int i;
        for (i = 0; i < 5; i++) begin
            step();
            if (i == 4) begin
                rst_n_i <= 1'b1;                     // fifth reset edge already taken
            end
            @(negedge clk);
            check_quiet();
        end
        repeat (3) begin
            step();
            @(negedge clk);
            check_quiet();
        end
    endtask

    task automatic test_logic();
        logic [4:0] ra;
        logic [4:0] rb;
        int         i;
        for (i = 0; i < 3; i++) begin
            ra = pick_reg();
            rb = pick_other(ra, ra);
            load_reg(ra, rand_word());
            load_reg(rb, rand_word());
            issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_OR));
            issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_AND));
            issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_XOR));
            issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_NOR));
            issue(i_word(`OPC_ANDI, ra, pick_other(ra, rb), 16'(rand_word())));
            issue(i_word(`OPC_XORI, rb, pick_other(ra, rb), 16'(rand_word())));
        end
        flush();
    endtask

    task automatic test_shift();
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] sa;
        int         i;
        for (i = 0; i < 3; i++) begin
            ra = pick_reg();
            rb = pick_other(ra, ra);
            sa = 5'(rand_word());
            load_reg(ra, rand_word() | 32'h8000_0000);  // negative for sign fill
            load_reg(rb, rand_word());
            issue(r_word(5'd0, ra, pick_other(ra, rb), sa, `FN_SRA));
            issue(r_word(rb, ra, pick_other(ra, rb), 5'd0, `FN_SRAV));
            issue(r_word(5'd0, ra, pick_other(ra, rb), sa, `FN_SLL));
            issue(r_word(5'd0, ra, pick_other(ra, rb), sa, `FN_SRL));
            issue(r_word(rb, ra, pick_other(ra, rb), 5'd0, `FN_SLLV));
            issue(r_word(rb, ra, pick_other(ra, rb), 5'd0, `FN_SRLV));
        end
        flush();
    endtask

    task automatic test_arith();
        logic [4:0] ra;
        logic [4:0] rb;
        int         i;
        for (i = 0; i < 2; i++) begin
            ra = pick_reg();
            rb = pick_other(ra, ra);
            load_reg(ra, rand_word());
            load_reg(rb, rand_word());
            issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_ADD));
            issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_ADDU));
            issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_SUB));
            issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_SUBU));
            issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_SLT));
            issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_SLTU));
            issue(i_word(`OPC_ADDI, ra, pick_other(ra, rb), 16'h8000 | 16'(rand_word())));
            issue(i_word(`OPC_ADDIU, rb, pick_other(ra, rb), 16'h8000 | 16'(rand_word())));
        end
        // sign boundaries and wrap-around
        load_reg(ra, 32'h7FFF_FFFF);
        load_reg(rb, 32'h8000_0000);
        issue(i_word(`OPC_SLTI, rb, pick_other(ra, rb), 16'h0000));
        issue(i_word(`OPC_SLTI, ra, pick_other(ra, rb), 16'h8000));
        issue(i_word(`OPC_SLTIU, rb, pick_other(ra, rb), 16'hFFFF));
        issue(i_word(`OPC_SLTIU, ra, pick_other(ra, rb), 16'h8000));
        issue(i_word(`OPC_ADDI, ra, pick_other(ra, rb), 16'h0001));
        issue(r_word(rb, rb, pick_other(ra, rb), 5'd0, `FN_ADD));
        issue(r_word(ra, rb, pick_other(ra, rb), 5'd0, `FN_SUB));
        flush();
    endtask

    task automatic test_forward();
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rc;
        int         i;
        for (i = 0; i < 3; i++) begin
            ra = pick_reg();
            rb = pick_other(ra, ra);
            rc = pick_other(ra, rb);
            issue(i_word(`OPC_ADDIU, 5'd0, ra, 16'(rand_word())));
            issue(r_word(ra, ra, rb, 5'd0, `FN_ADDU));   // distance 1
            issue(r_word(ra, rb, rc, 5'd0, `FN_SUBU));   // distance 2 and 1
            issue(r_word(ra, rc, rb, 5'd0, `FN_XOR));    // distance 3 on ra
            bubble();
            issue(r_word(rb, ra, rc, 5'd0, `FN_OR));     // distance 2 across a bubble
        end
        issue(i_word(`OPC_ADDIU, ra, 5'd0, 16'h1234));
        issue(r_word(5'd0, ra, rb, 5'd0, `FN_OR));
        issue(r_word(ra, ra, 5'd0, 5'd0, `FN_ADDU));
        issue(r_word(5'd0, 5'd0, rc, 5'd0, `FN_ADDU));
        flush();
    endtask

    task automatic test_invalid();
        logic [4:0] ra;
        ra = pick_reg();
        load_reg(ra, rand_word());
        issue({6'b100011, 26'(rand_word())});            // lw is not kept
        issue(r_word(ra, ra, pick_other(ra, ra), 5'd0, 6'b011000));  // mult
        issue(r_word(5'd0, 5'd0, 5'd0, 5'd0, `FN_SYNC));
        issue(i_word(`OPC_PREF, ra, 5'd3, 16'(rand_word())));
        issue({6'b000010, 26'(rand_word())});            // j
        issue(r_word(ra, ra, pick_other(ra, ra), 5'd0, `FN_ADDU));
        flush();
    endtask

    initial begin : check_outputs
        logic                   e_we;
        logic [`REG_ADDR_W-1:0] e_addr;
        logic [`INST_W-1:0]     e_data;
        logic                   e_inv;
        wait (rst_n_i === 1'b1);
        forever begin
            @(negedge clk);
            if (t_q.size() != 0 && t_q[0] + WB_DUE == $time) begin
                void'(t_q.pop_front());
                e_we   = we_q.pop_front();
                e_addr = addr_q.pop_front();
                e_data = data_q.pop_front();
                e_inv  = inv_q.pop_front();
                assert (wb_we_o === e_we)
                    else report_value("wb_we_o", 32'(e_we), 32'(wb_we_o));
                if (e_we) begin
                    assert (wb_addr_o === e_addr)
                        else report_value("wb_addr_o", 32'(e_addr), 32'(wb_addr_o));
                    assert (wb_data_o === e_data)
                        else report_value("wb_data_o", e_data, wb_data_o);
                end
                assert (inst_invalid_o === e_inv)
                    else report_value("inst_invalid_o", 32'(e_inv), 32'(inst_invalid_o));
            end else begin
                check_quiet();                       // bubble or nothing due
            end
        end
    end

    initial begin : watchdog
        while ($time <= (n_slots + 20) * CLK_PERIOD) begin
            @(negedge clk);
        end
        $display("watchdog expired, the stimulus stopped advancing at %0t ns", $time);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int k;
        seed         = 4;
        n_errors     = 0;
        n_issued     = 0;
        n_slots      = 0;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        for (k = 0; k < `REG_NUM; k++) begin
            model[k] = '0;
        end
        test_reset();
        test_logic();
        test_shift();
        test_arith();
        test_forward();
        test_invalid();
        $display("run finished, %0d errors over %0d instructions", n_errors, n_issued);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_int_top.f ====
+incdir+design
design/mips_int_pkg.sv
design/inst_decode.sv
design/alu_exec.sv
design/write_back.sv
design/mips_int_top.sv
bench/tb_mips_int.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mips_int testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_mips_int \
    -f mips_int_top.f \
    -Mdir obj_dir -o tb_mips_int

./obj_dir/tb_mips_int > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "simulation ended without a result line, see $LOG"
    exit 1
fi
echo "simulation passed"
